// File: Makefile
# Verilator build and run of the raster frame testbench.

VERILATOR ?= verilator
TOP       ?= raster_frame_tb
VFLAGS    ?= --binary --timing --assert
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
logic/draw_pkg.sv
logic/background_filler.sv
logic/pixel_scanner.sv
logic/edge_evaluator.sv
logic/fragment_writer.sv
logic/frame_sequencer.sv
logic/raster_frame_top.sv
testbench/raster_frame_tb.sv

// File: logic/background_filler.sv
`timescale 1ns/1ps

module background_filler (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        fill_start,
    output logic                        fill_en,
    output logic [draw_pkg::addr_w-1:0] fill_addr,
    output logic [draw_pkg::data_w-1:0] fill_data,
    output logic                        fill_done
);

    localparam logic [draw_pkg::addr_w-1:0] last_addr =
        draw_pkg::addr_w'(draw_pkg::buffer_pixels - 1);

    logic                        busy;
    logic [draw_pkg::addr_w-1:0] count;

    // One address per cycle, starting the cycle after fill_start.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (fill_start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            if (count == last_addr) begin
                busy <= 1'b0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign fill_en   = busy;
    assign fill_addr = count;
    assign fill_data = draw_pkg::background_color;
    assign fill_done = busy && (count == last_addr);

    a_fill_addr_range : assert property (@(posedge clk) disable iff (!rstn)
        fill_en |-> (fill_addr < draw_pkg::addr_w'(draw_pkg::buffer_pixels)))
        else $error("fill_addr out of range: %h", fill_addr);

endmodule

// File: logic/draw_pkg.sv
package draw_pkg;

    // Buffer geometry.
    localparam int buffer_width  = 160;
    localparam int buffer_height = 120;
    localparam int buffer_pixels = buffer_width * buffer_height;

    localparam int addr_w  = 15;
    localparam int data_w  = 12;
    localparam int coord_w = 8;
    localparam int edge_w  = 18;

    // Pixels are 4 bits each of red, green and blue.
    localparam logic [data_w-1:0] background_color = 12'h112;
    localparam logic [data_w-1:0] outside_color    = 12'h888;

    // Cycles from a scanner pixel to its three edge values.
    localparam int edge_latency = 2;

    typedef enum logic [1:0] {
        idle,
        background,
        raster,
        frame_wait
    } frame_state_t;

    typedef enum logic {
        scan_idle,
        scan_run
    } scan_state_t;

endpackage

// File: logic/edge_evaluator.sv
`timescale 1ns/1ps

module edge_evaluator (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic        [draw_pkg::coord_w-1:0] pix_x,
    input  logic        [draw_pkg::coord_w-1:0] pix_y,
    input  logic        [draw_pkg::coord_w-1:0] ax,
    input  logic        [draw_pkg::coord_w-1:0] ay,
    input  logic        [draw_pkg::coord_w-1:0] bx,
    input  logic        [draw_pkg::coord_w-1:0] by,
    output logic signed [draw_pkg::edge_w-1:0]  edge_value
);

    // Differences need one extra bit for the sign.
    logic signed [draw_pkg::coord_w:0] px_ax, py_ay, by_ay, bx_ax;
    logic signed [draw_pkg::edge_w-1:0] prod_x, prod_y;

    always_comb begin
        px_ax = $signed({1'b0, pix_x}) - $signed({1'b0, ax});
        py_ay = $signed({1'b0, pix_y}) - $signed({1'b0, ay});
        by_ay = $signed({1'b0, by}) - $signed({1'b0, ay});
        bx_ax = $signed({1'b0, bx}) - $signed({1'b0, ax});
    end

    // Stage one registers both products, stage two their difference.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_x     <= '0;
            prod_y     <= '0;
            edge_value <= '0;
        end else begin
            prod_x     <= draw_pkg::edge_w'(px_ax) * draw_pkg::edge_w'(by_ay);
            prod_y     <= draw_pkg::edge_w'(py_ay) * draw_pkg::edge_w'(bx_ax);
            edge_value <= prod_x - prod_y;
        end
    end

endmodule

// File: logic/fragment_writer.sv
`timescale 1ns/1ps

module fragment_writer (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               pix_valid,
    input  logic        [draw_pkg::coord_w-1:0] pix_x,
    input  logic        [draw_pkg::coord_w-1:0] pix_y,
    input  logic                               pix_last,
    input  logic signed [draw_pkg::edge_w-1:0]  edge_value0,
    input  logic signed [draw_pkg::edge_w-1:0]  edge_value1,
    input  logic signed [draw_pkg::edge_w-1:0]  edge_value2,
    input  logic        [3:0]                  color,
    output logic                               frag_en,
    output logic        [draw_pkg::addr_w-1:0]  frag_addr,
    output logic        [draw_pkg::data_w-1:0]  frag_data,
    output logic                               raster_done
);

    localparam int last = draw_pkg::edge_latency - 1;

    logic [draw_pkg::edge_latency-1:0] valid_d, last_d;
    logic [draw_pkg::coord_w-1:0]      x_d [draw_pkg::edge_latency];
    logic [draw_pkg::coord_w-1:0]      y_d [draw_pkg::edge_latency];
    logic                              all_pos, all_neg;

    // Delay line matching the edge evaluator pipeline.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_d <= '0;
            last_d  <= '0;
        end else begin
            valid_d <= {valid_d[draw_pkg::edge_latency-2:0], pix_valid};
            last_d  <= {last_d[draw_pkg::edge_latency-2:0], pix_last};
        end
    end

    always_ff @(posedge clk) begin
        x_d[0] <= pix_x;
        y_d[0] <= pix_y;
        for (int i = 1; i < draw_pkg::edge_latency; i++) begin
            x_d[i] <= x_d[i-1];
            y_d[i] <= y_d[i-1];
        end
    end

    // Either winding counts, so accept all-positive or all-negative.
    assign all_pos = (edge_value0 >= 0) && (edge_value1 >= 0) && (edge_value2 >= 0);
    assign all_neg = (edge_value0 <= 0) && (edge_value1 <= 0) && (edge_value2 <= 0);

    assign frag_en     = valid_d[last];
    assign frag_addr   = draw_pkg::addr_w'(x_d[last]) +
                         draw_pkg::addr_w'(y_d[last]) * draw_pkg::addr_w'(draw_pkg::buffer_width);
    assign frag_data   = (all_pos || all_neg) ? {4'h0, color, 4'h0} : draw_pkg::outside_color;
    assign raster_done = last_d[last];

    a_done_with_frag : assert property (@(posedge clk) disable iff (!rstn)
        raster_done |-> frag_en)
        else $error("raster_done without a fragment");

endmodule

// File: logic/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        draw_start,
    input  logic                        draw_ack,
    input  logic [3:0]                  sw,
    input  logic                        fill_done,
    input  logic                        fill_en,
    input  logic [draw_pkg::addr_w-1:0] fill_addr,
    input  logic [draw_pkg::data_w-1:0] fill_data,
    input  logic                        raster_done,
    input  logic                        frag_en,
    input  logic [draw_pkg::addr_w-1:0] frag_addr,
    input  logic [draw_pkg::data_w-1:0] frag_data,
    output logic                        fill_start,
    output logic                        scan_start,
    output logic [3:0]                  color,
    output logic                        write_en,
    output logic [draw_pkg::addr_w-1:0] write_addr,
    output logic [draw_pkg::data_w-1:0] write_data,
    output logic                        frame_done
);

    draw_pkg::frame_state_t state, next_state;

    always_comb begin
        next_state = state;
        fill_start = 1'b0;
        case (state)
            draw_pkg::idle: begin
                if (draw_start) begin
                    next_state = draw_pkg::background;
                    fill_start = 1'b1;
                end
            end
            draw_pkg::background: begin
                if (fill_done) next_state = draw_pkg::raster;
            end
            draw_pkg::raster: begin
                if (raster_done) next_state = draw_pkg::frame_wait;
            end
            draw_pkg::frame_wait: begin
                if (draw_ack) begin
                    next_state = draw_pkg::background;
                    fill_start = 1'b1;
                end
            end
            default: next_state = draw_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= draw_pkg::idle;
            scan_start <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            state      <= next_state;
            scan_start <= (state == draw_pkg::background) && fill_done;
            if (state == draw_pkg::raster && raster_done) begin
                frame_done <= 1'b1;
            end else if (state == draw_pkg::frame_wait && draw_ack) begin
                frame_done <= 1'b0;
            end
        end
    end

    // The switch value holds for the whole frame.
    always_ff @(posedge clk) begin
        if (fill_start) color <= sw;
    end

    always_comb begin
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        if (state == draw_pkg::background) begin
            write_en   = fill_en;
            write_addr = fill_addr;
            write_data = fill_data;
        end else if (state == draw_pkg::raster) begin
            write_en   = frag_en;
            write_addr = frag_addr;
            write_data = frag_data;
        end
    end

    a_done_in_wait : assert property (@(posedge clk) disable iff (!rstn)
        frame_done == (state == draw_pkg::frame_wait))
        else $error("frame_done %b in state %s", frame_done, state.name());

    a_writes_in_phase : assert property (@(posedge clk) disable iff (!rstn)
        (fill_en || frag_en || write_en) |->
            (state == draw_pkg::background || state == draw_pkg::raster))
        else $error("write outside a drawing phase in state %s", state.name());

endmodule

// File: logic/pixel_scanner.sv
`timescale 1ns/1ps

module pixel_scanner (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         scan_start,
    input  logic [draw_pkg::coord_w-1:0] v0_x,
    input  logic [draw_pkg::coord_w-1:0] v0_y,
    input  logic [draw_pkg::coord_w-1:0] v1_x,
    input  logic [draw_pkg::coord_w-1:0] v1_y,
    input  logic [draw_pkg::coord_w-1:0] v2_x,
    input  logic [draw_pkg::coord_w-1:0] v2_y,
    output logic [draw_pkg::coord_w-1:0] vtx_x0,
    output logic [draw_pkg::coord_w-1:0] vtx_y0,
    output logic [draw_pkg::coord_w-1:0] vtx_x1,
    output logic [draw_pkg::coord_w-1:0] vtx_y1,
    output logic [draw_pkg::coord_w-1:0] vtx_x2,
    output logic [draw_pkg::coord_w-1:0] vtx_y2,
    output logic                         pix_valid,
    output logic [draw_pkg::coord_w-1:0] pix_x,
    output logic [draw_pkg::coord_w-1:0] pix_y,
    output logic                         pix_last
);

    localparam logic [draw_pkg::coord_w-1:0] x_limit =
        draw_pkg::coord_w'(draw_pkg::buffer_width - 1);
    localparam logic [draw_pkg::coord_w-1:0] y_limit =
        draw_pkg::coord_w'(draw_pkg::buffer_height - 1);

    draw_pkg::scan_state_t state;

    logic [draw_pkg::coord_w-1:0] x_min, x_max, y_min, y_max;
    logic [draw_pkg::coord_w-1:0] cur_x, cur_y;
    logic [draw_pkg::coord_w-1:0] box_x_min, box_x_max, box_y_min, box_y_max;

    function automatic logic [draw_pkg::coord_w-1:0] min3(
        input logic [draw_pkg::coord_w-1:0] a,
        input logic [draw_pkg::coord_w-1:0] b,
        input logic [draw_pkg::coord_w-1:0] c
    );
        logic [draw_pkg::coord_w-1:0] m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic logic [draw_pkg::coord_w-1:0] max3(
        input logic [draw_pkg::coord_w-1:0] a,
        input logic [draw_pkg::coord_w-1:0] b,
        input logic [draw_pkg::coord_w-1:0] c
    );
        logic [draw_pkg::coord_w-1:0] m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Box bounds come straight from the ports so the first pixel is ready
    // on the cycle after scan_start.
    always_comb begin
        box_x_min = min3(v0_x, v1_x, v2_x);
        box_x_max = max3(v0_x, v1_x, v2_x);
        box_y_min = min3(v0_y, v1_y, v2_y);
        box_y_max = max3(v0_y, v1_y, v2_y);
        if (box_x_min > x_limit) box_x_min = x_limit;
        if (box_x_max > x_limit) box_x_max = x_limit;
        if (box_y_min > y_limit) box_y_min = y_limit;
        if (box_y_max > y_limit) box_y_max = y_limit;
    end

    always_ff @(posedge clk) begin
        if (scan_start) begin
            vtx_x0 <= v0_x;
            vtx_y0 <= v0_y;
            vtx_x1 <= v1_x;
            vtx_y1 <= v1_y;
            vtx_x2 <= v2_x;
            vtx_y2 <= v2_y;
            x_min  <= box_x_min;
            x_max  <= box_x_max;
            y_min  <= box_y_min;
            y_max  <= box_y_max;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= draw_pkg::scan_idle;
            cur_x <= '0;
            cur_y <= '0;
        end else if (scan_start) begin
            state <= draw_pkg::scan_run;
            cur_x <= box_x_min;
            cur_y <= box_y_min;
        end else if (state == draw_pkg::scan_run) begin
            if (cur_x == x_max) begin
                cur_x <= x_min;
                if (cur_y == y_max) begin
                    state <= draw_pkg::scan_idle;
                end else begin
                    cur_y <= cur_y + 1'b1;
                end
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    assign pix_valid = (state == draw_pkg::scan_run);
    assign pix_x     = cur_x;
    assign pix_y     = cur_y;
    assign pix_last  = pix_valid && (cur_x == x_max) && (cur_y == y_max);

    a_pix_in_box : assert property (@(posedge clk) disable iff (!rstn)
        pix_valid |-> (pix_x >= x_min && pix_x <= x_max &&
                       pix_y >= y_min && pix_y <= y_max))
        else $error("pixel (%h,%h) outside box", pix_x, pix_y);

endmodule

// File: logic/raster_frame_top.sv
`timescale 1ns/1ps

module raster_frame_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         draw_start,
    input  logic                         draw_ack,
    input  logic [3:0]                   sw,
    input  logic [draw_pkg::coord_w-1:0] v0_x,
    input  logic [draw_pkg::coord_w-1:0] v0_y,
    input  logic [draw_pkg::coord_w-1:0] v1_x,
    input  logic [draw_pkg::coord_w-1:0] v1_y,
    input  logic [draw_pkg::coord_w-1:0] v2_x,
    input  logic [draw_pkg::coord_w-1:0] v2_y,
    output logic                         write_en,
    output logic [draw_pkg::addr_w-1:0]  write_addr,
    output logic [draw_pkg::data_w-1:0]  write_data,
    output logic                         frame_done
);

    logic                        fill_start, fill_en, fill_done;
    logic [draw_pkg::addr_w-1:0] fill_addr;
    logic [draw_pkg::data_w-1:0] fill_data;

    logic                         scan_start, pix_valid, pix_last;
    logic [draw_pkg::coord_w-1:0] pix_x, pix_y;
    logic [draw_pkg::coord_w-1:0] vtx_x [3];
    logic [draw_pkg::coord_w-1:0] vtx_y [3];

    logic signed [draw_pkg::edge_w-1:0] edge_value [3];

    logic                        frag_en, raster_done;
    logic [draw_pkg::addr_w-1:0] frag_addr;
    logic [draw_pkg::data_w-1:0] frag_data;
    logic [3:0]                  color;

    frame_sequencer u_sequencer (
        .clk        (clk),
        .rstn       (rstn),
        .draw_start (draw_start),
        .draw_ack   (draw_ack),
        .sw         (sw),
        .fill_done  (fill_done),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .raster_done(raster_done),
        .frag_en    (frag_en),
        .frag_addr  (frag_addr),
        .frag_data  (frag_data),
        .fill_start (fill_start),
        .scan_start (scan_start),
        .color      (color),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .frame_done (frame_done)
    );

    background_filler u_filler (
        .clk       (clk),
        .rstn      (rstn),
        .fill_start(fill_start),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .fill_done (fill_done)
    );

    pixel_scanner u_scanner (
        .clk       (clk),
        .rstn      (rstn),
        .scan_start(scan_start),
        .v0_x      (v0_x),
        .v0_y      (v0_y),
        .v1_x      (v1_x),
        .v1_y      (v1_y),
        .v2_x      (v2_x),
        .v2_y      (v2_y),
        .vtx_x0    (vtx_x[0]),
        .vtx_y0    (vtx_y[0]),
        .vtx_x1    (vtx_x[1]),
        .vtx_y1    (vtx_y[1]),
        .vtx_x2    (vtx_x[2]),
        .vtx_y2    (vtx_y[2]),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_last  (pix_last)
    );

    // Edge i runs from vertex i to the next vertex.
    for (genvar i = 0; i < 3; i++) begin : g_edge
        edge_evaluator u_edge (
            .clk       (clk),
            .rstn      (rstn),
            .pix_x     (pix_x),
            .pix_y     (pix_y),
            .ax        (vtx_x[i]),
            .ay        (vtx_y[i]),
            .bx        (vtx_x[(i+1)%3]),
            .by        (vtx_y[(i+1)%3]),
            .edge_value(edge_value[i])
        );
    end

    fragment_writer u_writer (
        .clk        (clk),
        .rstn       (rstn),
        .pix_valid  (pix_valid),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_last   (pix_last),
        .edge_value0(edge_value[0]),
        .edge_value1(edge_value[1]),
        .edge_value2(edge_value[2]),
        .color      (color),
        .frag_en    (frag_en),
        .frag_addr  (frag_addr),
        .frag_data  (frag_data),
        .raster_done(raster_done)
    );

endmodule

// File: testbench/raster_frame_tb.sv
`timescale 1ns/1ps

module raster_frame_tb;

    localparam int cycle_limit = 4 * (2 * draw_pkg::buffer_pixels + 16) + 200;

    logic                         clk;
    logic                         rstn;
    logic                         draw_start;
    logic                         draw_ack;
    logic [3:0]                   sw;
    logic [draw_pkg::coord_w-1:0] v0_x, v0_y, v1_x, v1_y, v2_x, v2_y;
    logic                         write_en;
    logic [draw_pkg::addr_w-1:0]  write_addr;
    logic [draw_pkg::data_w-1:0]  write_data;
    logic                         frame_done;

    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    // Reference model state.
    draw_pkg::frame_state_t      phase;
    logic                        frame_start;
    int                          m_vx [3];
    int                          m_vy [3];
    logic [3:0]                  m_color;
    int                          bg_index;
    int                          ras_x, ras_y;
    int                          box_x0, box_x1, box_y0, box_y1;
    logic [draw_pkg::addr_w-1:0] exp_addr;
    logic [draw_pkg::data_w-1:0] exp_data;

    raster_frame_top dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .draw_start(draw_start),
        .draw_ack  (draw_ack),
        .sw        (sw),
        .v0_x      (v0_x),
        .v0_y      (v0_y),
        .v1_x      (v1_x),
        .v1_y      (v1_y),
        .v2_x      (v2_x),
        .v2_y      (v2_y),
        .write_en  (write_en),
        .write_addr(write_addr),
        .write_data(write_data),
        .frame_done(frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1 give a maximal length sequence.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic random_coord(input int limit, output int value);
        logic [31:0] bits;
        do begin
            draw_bits(8, bits);
        end while (bits >= 32'(limit));
        value = int'(bits);
    endtask

    function automatic logic pixel_inside(input int x, input int y);
        int e [3];
        int b;
        for (int i = 0; i < 3; i++) begin
            b    = (i + 1) % 3;
            e[i] = (x - m_vx[i]) * (m_vy[b] - m_vy[i]) - (y - m_vy[i]) * (m_vx[b] - m_vx[i]);
        end
        return (e[0] >= 0 && e[1] >= 0 && e[2] >= 0) || (e[0] <= 0 && e[1] <= 0 && e[2] <= 0);
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        value_errors++;
        $display("** Error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
                 $time);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    assign frame_start = (phase == draw_pkg::idle && draw_start) ||
                         (phase == draw_pkg::frame_wait && draw_ack);

    always_comb begin
        box_x0 = m_vx[0];
        box_x1 = m_vx[0];
        box_y0 = m_vy[0];
        box_y1 = m_vy[0];
        for (int i = 1; i < 3; i++) begin
            if (m_vx[i] < box_x0) box_x0 = m_vx[i];
            if (m_vx[i] > box_x1) box_x1 = m_vx[i];
            if (m_vy[i] < box_y0) box_y0 = m_vy[i];
            if (m_vy[i] > box_y1) box_y1 = m_vy[i];
        end
        if (box_x0 > draw_pkg::buffer_width - 1) box_x0 = draw_pkg::buffer_width - 1;
        if (box_x1 > draw_pkg::buffer_width - 1) box_x1 = draw_pkg::buffer_width - 1;
        if (box_y0 > draw_pkg::buffer_height - 1) box_y0 = draw_pkg::buffer_height - 1;
        if (box_y1 > draw_pkg::buffer_height - 1) box_y1 = draw_pkg::buffer_height - 1;
    end

    always_comb begin
        exp_addr = draw_pkg::addr_w'(bg_index);
        exp_data = draw_pkg::background_color;
        if (phase == draw_pkg::raster) begin
            exp_addr = draw_pkg::addr_w'(ras_x + draw_pkg::buffer_width * ras_y);
            if (pixel_inside(ras_x, ras_y)) begin
                exp_data = {4'h0, m_color, 4'h0};
            end else begin
                exp_data = draw_pkg::outside_color;
            end
        end
    end

    // The model advances once per observed write.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase    <= draw_pkg::idle;
            m_color  <= '0;
            bg_index <= 0;
            ras_x    <= 0;
            ras_y    <= 0;
            m_vx     <= '{0, 0, 0};
            m_vy     <= '{0, 0, 0};
        end else if (frame_start) begin
            phase    <= draw_pkg::background;
            m_color  <= sw;
            bg_index <= 0;
            m_vx     <= '{int'(v0_x), int'(v1_x), int'(v2_x)};
            m_vy     <= '{int'(v0_y), int'(v1_y), int'(v2_y)};
        end else if (write_en && phase == draw_pkg::background) begin
            if (bg_index == draw_pkg::buffer_pixels - 1) begin
                phase <= draw_pkg::raster;
                ras_x <= box_x0;
                ras_y <= box_y0;
            end else begin
                bg_index <= bg_index + 1;
            end
        end else if (write_en && phase == draw_pkg::raster) begin
            if (ras_x == box_x1) begin
                ras_x <= box_x0;
                if (ras_y == box_y1) phase <= draw_pkg::frame_wait;
                else ras_y <= ras_y + 1;
            end else begin
                ras_x <= ras_x + 1;
            end
        end
    end

    a_idle_write : assert property (@(posedge clk) disable iff (!rstn)
        (phase == draw_pkg::idle) |-> !write_en)
        else report_value("write_en", 32'h0, 32'($sampled(write_en)));

    a_write_phase : assert property (@(posedge clk) disable iff (!rstn)
        write_en |-> (phase == draw_pkg::background || phase == draw_pkg::raster))
        else report_failure("a write arrived after the frame's last expected pixel");

    a_write_addr : assert property (@(posedge clk) disable iff (!rstn)
        (write_en && (phase == draw_pkg::background || phase == draw_pkg::raster))
            |-> (write_addr == exp_addr))
        else report_value("write_addr", 32'($sampled(exp_addr)), 32'($sampled(write_addr)));

    a_write_data : assert property (@(posedge clk) disable iff (!rstn)
        (write_en && (phase == draw_pkg::background || phase == draw_pkg::raster))
            |-> (write_data == exp_data))
        else report_value("write_data", 32'($sampled(exp_data)), 32'($sampled(write_data)));

    a_frame_done : assert property (@(posedge clk) disable iff (!rstn)
        frame_done == (phase == draw_pkg::frame_wait))
        else report_value("frame_done", 32'($sampled(phase == draw_pkg::frame_wait)),
                          32'($sampled(frame_done)));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("Timeout: the frames did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic set_triangle(input int x0, input int y0, input int x1, input int y1,
                                input int x2, input int y2);
        v0_x = draw_pkg::coord_w'(x0);
        v0_y = draw_pkg::coord_w'(y0);
        v1_x = draw_pkg::coord_w'(x1);
        v1_y = draw_pkg::coord_w'(y1);
        v2_x = draw_pkg::coord_w'(x2);
        v2_y = draw_pkg::coord_w'(y2);
    endtask

    task automatic random_frame_inputs();
        int          c [6];
        logic [31:0] bits;
        for (int i = 0; i < 3; i++) begin
            random_coord(draw_pkg::buffer_width, c[2*i]);
            random_coord(draw_pkg::buffer_height, c[2*i+1]);
        end
        set_triangle(c[0], c[1], c[2], c[3], c[4], c[5]);
        draw_bits(4, bits);
        sw = bits[3:0];
    endtask

    task automatic pulse_start();
        draw_start = 1'b1;
        @(negedge clk);
        draw_start = 1'b0;
    endtask

    task automatic pulse_ack();
        draw_ack = 1'b1;
        @(negedge clk);
        draw_ack = 1'b0;
    endtask

    task automatic wait_frame_done();
        do begin
            @(negedge clk);
        end while (!frame_done);
    endtask

    initial begin
        lfsr         = 32'h889f;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        rstn         = 1'b0;
        draw_start   = 1'b0;
        draw_ack     = 1'b0;
        sw           = 4'h0;
        set_triangle(0, 0, 0, 0, 0, 0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (8) @(negedge clk);

        // A small triangle first, then a collinear one.
        // The switches change during each frame, so only the latched value may colour it.
        set_triangle(5, 3, 12, 9, 2, 8);
        sw = 4'ha;
        pulse_start();
        sw = ~sw;
        wait_frame_done();
        set_triangle(20, 30, 60, 50, 100, 70);
        sw = 4'h5;
        pulse_ack();
        sw = ~sw;
        wait_frame_done();
        for (int f = 0; f < 2; f++) begin
            random_frame_inputs();
            pulse_ack();
            sw = ~sw;
            wait_frame_done();
        end
        repeat (4) @(negedge clk);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
